/* source/epu_config.svh */
`ifndef EPU_CONFIG_SVH
`define EPU_CONFIG_SVH

// bias buffer geometry, one word per output channel
`define BIAS_ADDR_W 6
`define BIAS_DEPTH  (1 << `BIAS_ADDR_W)

// host word and accumulator width
`define DATA_W 32

// saturated result width
`define OUT_W 16

// host address space covers the buffer plus the command register
`define HOST_ADDR_W (`BIAS_ADDR_W + 1)
`define CMD_ADDR    `HOST_ADDR_W'(`BIAS_DEPTH)

// right shift amount field in the command word
`define SHIFT_W 4

`endif

/* source/epu_pkg.sv */
`include "epu_config.svh"

package epu_pkg;

  // raw accumulator and bias values
  typedef logic signed [`DATA_W-1:0] acc_t;

  // post-processed output value
  typedef logic signed [`OUT_W-1:0] out_t;

  // command register layout, load_done in bit 0
  typedef struct packed {
    logic [`DATA_W-`SHIFT_W-3:0] rsvd;
    logic [`SHIFT_W-1:0]         shift;
    logic                        relu_en;
    logic                        load_done;
  } epu_cmd_t;

  // one host word, read as a bias or as a command depending on address
  typedef union packed {
    acc_t     bias;
    epu_cmd_t cmd;
  } host_word_u;

  // who owns the bias buffer
  typedef enum logic [1:0] {
    OWN_IDLE      = 2'd0,
    OWN_HOST_LOAD = 2'd1,
    OWN_EPU       = 2'd2
  } own_mode_e;

endpackage

/* source/bias_mem_if.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

interface bias_mem_if
  import epu_pkg::*;
();

  logic                    cs;
  logic                    we;
  logic [`BIAS_ADDR_W-1:0] addr;
  acc_t                    wdata;
  // valid one cycle after a read access
  acc_t                    rdata;

  modport memory (
    input  cs,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

  modport client (
    output cs,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

endinterface

/* source/bias_sram.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

module bias_sram
  import epu_pkg::*;
(
  input logic       clk,
  bias_mem_if.memory mem
);

  acc_t mem_q [`BIAS_DEPTH];
  acc_t rdata_q;

  // single port, write has priority over read by construction of cs/we
  always_ff @(posedge clk) begin
    if (mem.cs) begin
      if (mem.we) begin
        mem_q[mem.addr] <= mem.wdata;
      end else begin
        rdata_q <= mem_q[mem.addr];
      end
    end
  end

  assign mem.rdata = rdata_q;

endmodule

/* source/bias_wrapper.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

module bias_wrapper
  import epu_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_start_i,
  input  logic                    load_fin_i,
  input  logic                    host_wr_en_i,
  input  logic [`BIAS_ADDR_W-1:0] host_addr_i,
  input  acc_t                    host_bias_i,
  input  logic                    epu_rd_i,
  input  logic [`BIAS_ADDR_W-1:0] epu_chan_i,
  output own_mode_e               mode_o,
  output acc_t                    bias_o,
  bias_mem_if.client              mem
);

  own_mode_e state_q;
  own_mode_e state_d;
  logic      host_owns;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= OWN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      OWN_IDLE:      if (load_start_i) state_d = OWN_HOST_LOAD;
      OWN_HOST_LOAD: if (load_fin_i) state_d = OWN_EPU;
      OWN_EPU:       if (load_start_i) state_d = OWN_HOST_LOAD;
      default:       state_d = OWN_IDLE;
    endcase
  end

  // the first bias write arrives together with load_start, before the state moves
  assign host_owns = (state_q == OWN_HOST_LOAD) || load_start_i;

  always_comb begin
    if (host_owns) begin
      mem.cs    = host_wr_en_i;
      mem.we    = 1'b1;
      mem.addr  = host_addr_i;
      mem.wdata = host_bias_i;
    end else if (state_q == OWN_EPU) begin
      mem.cs    = epu_rd_i;
      mem.we    = 1'b0;
      mem.addr  = epu_chan_i;
      mem.wdata = '0;
    end else begin
      // idle keeps the port parked
      mem.cs    = 1'b0;
      mem.we    = 1'b0;
      mem.addr  = '0;
      mem.wdata = '0;
    end
  end

  assign mode_o = state_q;
  assign bias_o = mem.rdata;

endmodule

/* source/epu_ctrl.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

module epu_ctrl
  import epu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   host_wr_i,
  input  logic [`HOST_ADDR_W-1:0] host_addr_i,
  input  host_word_u             host_data_i,
  input  own_mode_e              mode_i,
  input  logic                   acc_valid_i,
  output logic                   load_start_o,
  output logic                   load_fin_o,
  output logic                   bias_wr_o,
  output logic                   issue_o,
  output logic                   drop_o,
  output logic [`SHIFT_W-1:0]    shift_o,
  output logic                   relu_en_o
);

  logic                cmd_wr;
  logic                accept;
  logic                drop_q;
  logic [`SHIFT_W-1:0] shift_q;
  logic                relu_en_q;

  // address decode
  assign bias_wr_o = host_wr_i && (host_addr_i < `CMD_ADDR);
  assign cmd_wr    = host_wr_i && (host_addr_i == `CMD_ADDR);

  // first bias write after idle or accelerator ownership starts a new load
  assign load_start_o = bias_wr_o && (mode_i != OWN_HOST_LOAD);
  assign load_fin_o   = cmd_wr && host_data_i.cmd.load_done;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shift_q   <= '0;
      relu_en_q <= 1'b0;
    end else if (load_fin_o) begin
      shift_q   <= host_data_i.cmd.shift;
      relu_en_q <= host_data_i.cmd.relu_en;
    end
  end

  // a restart in the same cycle takes the SRAM port away from the read
  assign accept  = (mode_i == OWN_EPU) && !load_start_o;
  assign issue_o = acc_valid_i && accept;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      drop_q <= 1'b0;
    end else begin
      drop_q <= acc_valid_i && !accept;
    end
  end

  assign drop_o    = drop_q;
  assign shift_o   = shift_q;
  assign relu_en_o = relu_en_q;

endmodule

/* source/bias_post_proc.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

module bias_post_proc
  import epu_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_i,
  input  acc_t                acc_i,
  input  acc_t                bias_i,
  input  logic [`SHIFT_W-1:0] shift_i,
  input  logic                relu_en_i,
  output logic                out_valid_o,
  output out_t                out_data_o
);

  localparam int OUT_MAX = 2 ** (`OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (`OUT_W - 1));

  // stage 1
  logic                s1_valid_q;
  acc_t                s1_acc_q;
  logic [`SHIFT_W-1:0] s1_shift_q;
  logic                s1_relu_q;

  // stage 2 datapath, one extra bit so the add cannot wrap
  logic signed [`DATA_W:0] sum;
  logic signed [`DATA_W:0] shifted;
  logic signed [`DATA_W:0] rectified;
  out_t                    sat;

  logic s2_valid_q;
  out_t s2_data_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= issue_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // command sampled with the result, so later changes do not affect it
  always_ff @(posedge clk) begin
    if (issue_i) begin
      s1_acc_q   <= acc_i;
      s1_shift_q <= shift_i;
      s1_relu_q  <= relu_en_i;
    end
  end

  always_comb begin
    sum       = s1_acc_q + bias_i;
    shifted   = sum >>> s1_shift_q;
    rectified = (s1_relu_q && shifted < 0) ? '0 : shifted;
    if (rectified > OUT_MAX) begin
      sat = out_t'(OUT_MAX);
    end else if (rectified < OUT_MIN) begin
      sat = out_t'(OUT_MIN);
    end else begin
      sat = out_t'(rectified);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid_q) begin
      s2_data_q <= sat;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign out_data_o  = s2_data_q;

endmodule

/* source/epu_bias_top.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

module epu_bias_top
  import epu_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    host_wr_i,
  input  logic [`HOST_ADDR_W-1:0] host_addr_i,
  input  logic [`DATA_W-1:0]      host_data_i,
  input  logic                    acc_valid_i,
  input  logic [`BIAS_ADDR_W-1:0] acc_chan_i,
  input  logic [`DATA_W-1:0]      acc_data_i,
  output logic                    out_valid_o,
  output logic [`OUT_W-1:0]       out_data_o,
  output logic                    drop_o
);

  host_word_u          host_word;
  own_mode_e           mode;
  acc_t                bias;
  logic                load_start;
  logic                load_fin;
  logic                bias_wr;
  logic                issue;
  logic [`SHIFT_W-1:0] shift;
  logic                relu_en;

  bias_mem_if bias_bus ();

  assign host_word = host_word_u'(host_data_i);

  epu_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .host_wr_i    (host_wr_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_word),
    .mode_i       (mode),
    .acc_valid_i  (acc_valid_i),
    .load_start_o (load_start),
    .load_fin_o   (load_fin),
    .bias_wr_o    (bias_wr),
    .issue_o      (issue),
    .drop_o       (drop_o),
    .shift_o      (shift),
    .relu_en_o    (relu_en)
  );

  bias_wrapper u_wrapper (
    .clk          (clk),
    .rst          (rst),
    .load_start_i (load_start),
    .load_fin_i   (load_fin),
    .host_wr_en_i (bias_wr),
    .host_addr_i  (host_addr_i[`BIAS_ADDR_W-1:0]),
    .host_bias_i  (host_word.bias),
    .epu_rd_i     (issue),
    .epu_chan_i   (acc_chan_i),
    .mode_o       (mode),
    .bias_o       (bias),
    .mem          (bias_bus.client)
  );

  bias_sram u_sram (
    .clk (clk),
    .mem (bias_bus.memory)
  );

  bias_post_proc u_post (
    .clk         (clk),
    .rst         (rst),
    .issue_i     (issue),
    .acc_i       (acc_t'(acc_data_i)),
    .bias_i      (bias),
    .shift_i     (shift),
    .relu_en_i   (relu_en),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

/* verification/epu_bias_checker.sv */
`timescale 1ns/1ps

module epu_bias_checker
  import epu_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      issue_i,
  input logic      drop_i,
  input logic      out_valid_i,
  input own_mode_e mode_i
);

  // each accepted result leaves the pipeline two cycles later, nothing else does
  a_out_latency: assert property (
    @(posedge clk) disable iff (rst) out_valid_i == $past(issue_i, 2)
  ) else $error("out_valid_o does not follow issue by two cycles");

  a_drop_issue_excl: assert property (
    @(posedge clk) disable iff (rst) !(drop_i && issue_i)
  ) else $error("drop_o and issue high together");

  a_issue_owner: assert property (
    @(posedge clk) disable iff (rst) issue_i |-> (mode_i == OWN_EPU)
  ) else $error("issue outside accelerator ownership");

  a_drop_reset: assert property (
    @(posedge clk) rst |-> !drop_i
  ) else $error("drop_o high during reset");

endmodule

bind epu_bias_top epu_bias_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .issue_i     (issue),
  .drop_i      (drop_o),
  .out_valid_i (out_valid_o),
  .mode_i      (mode)
);

/* verification/epu_bias_tb.sv */
`timescale 1ns/1ps
`include "epu_config.svh"

module epu_bias_tb
  import epu_pkg::*;
();

  typedef enum logic [1:0] {K_BIAS, K_CMD, K_ACC} kind_e;

  typedef struct {
    kind_e kind;
    int    idx;
    acc_t  data;
    logic  drop;
  } stim_t;

  typedef struct {
    out_t value;
    int   cycle;
  } exp_t;

  logic                    clk;
  logic                    rst;
  logic                    host_wr;
  logic [`HOST_ADDR_W-1:0] host_addr;
  logic [`DATA_W-1:0]      host_data;
  logic                    acc_valid;
  logic [`BIAS_ADDR_W-1:0] acc_chan;
  logic [`DATA_W-1:0]      acc_data;
  logic                    out_valid;
  logic [`OUT_W-1:0]       out_data;
  logic                    drop;

  stim_t     stim_q[$];
  exp_t      exp_q[$];
  exp_t      head;
  acc_t      ref_bias [`BIAS_DEPTH];
  int        ref_shift;
  logic      ref_relu;
  own_mode_e build_mode;
  logic      cur_drop;
  logic      drop_exp_q;
  int        cycle_cnt;
  int        timeout_limit;

  epu_bias_top UUT (
    .clk         (clk),
    .rst         (rst),
    .host_wr_i   (host_wr),
    .host_addr_i (host_addr),
    .host_data_i (host_data),
    .acc_valid_i (acc_valid),
    .acc_chan_i  (acc_chan),
    .acc_data_i  (acc_data),
    .out_valid_o (out_valid),
    .out_data_o  (out_data),
    .drop_o      (drop)
  );

  always begin
    #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_out(input out_t actual, input out_t expected);
    if (actual !== expected) begin
      $display("Error: out_data_o = %h, expected %h", actual, expected);
      abort_run();
    end
  endtask

  task automatic check_drop(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Error: drop_o = %h, expected %h", actual, expected);
      abort_run();
    end
  endtask

  // sum shifted right, optionally rectified, then clamped to 16 bits
  function automatic out_t expect_out(acc_t acc, acc_t bias, int shift, logic relu);
    longint v;
    v = longint'(acc) + longint'(bias);
    v = v >>> shift;
    if (relu && v < 0) begin
      v = 0;
    end
    if (v > 32767) begin
      return 16'sh7fff;
    end
    if (v < -32768) begin
      return 16'sh8000;
    end
    return out_t'(v);
  endfunction

  function automatic acc_t small_rand();
    int v;
    v = $urandom_range(32767, 0);
    return acc_t'(v - 16384);
  endfunction

  task automatic add_bias(input int addr, input acc_t value);
    stim_t s;
    s.kind = K_BIAS;
    s.idx  = addr;
    s.data = value;
    s.drop = 1'b0;
    stim_q.push_back(s);
    build_mode = OWN_HOST_LOAD;
  endtask

  task automatic add_cmd(input int shift, input logic relu);
    stim_t      s;
    host_word_u w;
    w.cmd.rsvd      = '0;
    w.cmd.shift     = shift[`SHIFT_W-1:0];
    w.cmd.relu_en   = relu;
    w.cmd.load_done = 1'b1;
    s.kind = K_CMD;
    s.idx  = 0;
    s.data = w.bias;
    s.drop = 1'b0;
    stim_q.push_back(s);
    if (build_mode == OWN_HOST_LOAD) begin
      build_mode = OWN_EPU;
    end
  endtask

  // results are only admitted while the accelerator owns the buffer
  task automatic add_acc(input int chan, input acc_t value);
    stim_t s;
    s.kind = K_ACC;
    s.idx  = chan;
    s.data = value;
    s.drop = (build_mode != OWN_EPU);
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    // nothing loaded yet
    add_acc(0, small_rand());
    add_acc(5, small_rand());
    for (int i = 0; i < `BIAS_DEPTH; i++) begin
      add_bias(i, small_rand());
      if (i == 20) begin
        add_acc(3, small_rand());
      end
    end
    add_cmd(0, 1'b0);
    for (int i = 0; i < `BIAS_DEPTH; i++) begin
      add_acc(i, small_rand());
    end
    // mixed sign sums through shift and relu
    add_cmd(3, 1'b1);
    for (int i = 0; i < 16; i++) begin
      add_acc(i, (i % 2) ? small_rand() + 40000 : small_rand() - 40000);
    end
    // clamp both ways
    add_cmd(0, 1'b0);
    add_acc(1, 32'sh4000_0000);
    add_acc(2, -32'sh4000_0000);
    add_acc(3, 32'sh7fff_ffff);
    add_acc(4, acc_t'(32'h8000_0000));
    // results between the reload writes get dropped
    add_bias(7, small_rand());
    add_acc(7, small_rand());
    add_bias(8, small_rand());
    add_acc(8, small_rand());
    add_cmd(1, 1'b0);
    add_acc(7, small_rand());
    add_acc(8, small_rand());
    // one result per cycle around a command change
    for (int i = 0; i < 8; i++) begin
      add_acc(i * 3, small_rand() * 4);
    end
    add_cmd(2, 1'b1);
    for (int i = 0; i < 8; i++) begin
      add_acc(i * 5 + 1, small_rand() * 4);
    end
  endtask

  task automatic apply_entry(input stim_t s);
    host_word_u w;
    exp_t       e;
    host_wr   = 1'b0;
    acc_valid = 1'b0;
    cur_drop  = 1'b0;
    case (s.kind)
      K_BIAS: begin
        host_wr   = 1'b1;
        host_addr = s.idx[`HOST_ADDR_W-1:0];
        host_data = s.data;
        ref_bias[s.idx] = s.data;
      end
      K_CMD: begin
        host_wr   = 1'b1;
        host_addr = `CMD_ADDR;
        host_data = s.data;
        w.bias    = s.data;
        ref_shift = w.cmd.shift;
        ref_relu  = w.cmd.relu_en;
      end
      default: begin
        acc_valid = 1'b1;
        acc_chan  = s.idx[`BIAS_ADDR_W-1:0];
        acc_data  = s.data;
        cur_drop  = s.drop;
        if (!s.drop) begin
          e.value = expect_out(s.data, ref_bias[s.idx], ref_shift, ref_relu);
          e.cycle = cycle_cnt + 2;
          exp_q.push_back(e);
        end
      end
    endcase
  endtask

  always @(posedge clk) begin
    cycle_cnt  <= cycle_cnt + 1;
    drop_exp_q <= cur_drop;
    if (cycle_cnt > timeout_limit) begin
      $display("Timeout: run exceeded %0d cycles", timeout_limit);
      abort_run();
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check_drop(drop, drop_exp_q);
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("Output valid with no result pending, data %h", out_data);
          abort_run();
        end else begin
          head = exp_q.pop_front();
          if (head.cycle != cycle_cnt) begin
            $display("Output came at cycle %0d instead of cycle %0d", cycle_cnt, head.cycle);
            abort_run();
          end else begin
            check_out(out_t'(out_data), head.value);
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h478));
    rst        = 1'b1;
    clk        = 1'b0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_data  = '0;
    acc_valid  = 1'b0;
    acc_chan   = '0;
    acc_data   = '0;
    cur_drop   = 1'b0;
    cycle_cnt  = 0;
    ref_shift  = 0;
    ref_relu   = 1'b0;
    build_mode = OWN_IDLE;
    build_table();
    timeout_limit = stim_q.size() * 4 + 50;
    repeat (10) @(posedge clk);
    #5 rst = 1'b0;
    foreach (stim_q[i]) begin
      @(posedge clk);
      #5;
      apply_entry(stim_q[i]);
    end
    @(posedge clk);
    #5;
    host_wr   = 1'b0;
    acc_valid = 1'b0;
    cur_drop  = 1'b0;
    // the last result leaves the pipeline two cycles after it was applied
    repeat (3) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* epu_bias_top.f */
+incdir+source
source/epu_pkg.sv
source/bias_mem_if.sv
source/bias_sram.sv
source/bias_wrapper.sv
source/epu_ctrl.sv
source/bias_post_proc.sv
source/epu_bias_top.sv
verification/epu_bias_checker.sv
verification/epu_bias_tb.sv

/* Bender.yml */
package:
  name: epu_bias

sources:
  - include_dirs:
      - source
    files:
      - source/epu_pkg.sv
      - source/bias_mem_if.sv
      - source/bias_sram.sv
      - source/bias_wrapper.sv
      - source/epu_ctrl.sv
      - source/bias_post_proc.sv
      - source/epu_bias_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/epu_bias_checker.sv
      - verification/epu_bias_tb.sv
